/* Bender.yml */
package:
  name: commit_trace

sources:
  - files:
      - rtl/core_cfg_pkg.sv
      - rtl/commit_trace_pkg.sv
      - rtl/commit_capture.sv
      - rtl/trace_fifo.sv
      - rtl/trace_rr_arbiter.sv
      - rtl/commit_trace_top.sv
  - target: test
    files:
      - tb/tb_commit_trace.sv

/* all.f */
rtl/core_cfg_pkg.sv
rtl/commit_trace_pkg.sv
rtl/commit_capture.sv
rtl/trace_fifo.sv
rtl/trace_rr_arbiter.sv
rtl/commit_trace_top.sv
tb/tb_commit_trace.sv

/* rtl/commit_capture.sv */
`timescale 1ns/1ps
// commit capture
// classifies and timestamps each acknowledged commit and registers a push per port

module commit_capture import core_cfg_pkg::*, commit_trace_pkg::*; #(
  parameter int unsigned NrPorts = 2
) (
  input  logic                           clk_i,
  input  logic                           rst_ni,
  input  logic [NrPorts-1:0]             commit_ack_i,
  input  logic [NrPorts-1:0]             commit_ex_valid_i,
  input  logic [NrPorts-1:0][VLEN-1:0]   commit_pc_i,
  input  logic [NrPorts-1:0][XLEN-1:0]   commit_cause_i,
  input  logic [NrPorts-1:0][TVAL_W-1:0] commit_tval_i,
  input  priv_lvl_t                      priv_lvl_i,
  input  logic                           debug_mode_i,
  output logic [NrPorts-1:0]             push_o,
  output trace_entry_t [NrPorts-1:0]     entry_o
);

  logic [CYCLE_W-1:0]         cycle_q;
  trace_mode_t                mode;
  trace_entry_t [NrPorts-1:0] entry_d;
  trace_entry_t [NrPorts-1:0] entry_q;
  logic [NrPorts-1:0]         push_q;

  // free-running stamp that reads zero in the first cycle out of reset
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cycle_q <= '0;
    end else begin
      cycle_q <= cycle_q + 1'b1;
    end
  end

  // ----------------------------------------
  // classification
  // ----------------------------------------
  // mode is shared by all ports in a cycle
  always_comb begin
    if (debug_mode_i) begin
      mode = MODE_DEBUG;
    end else begin
      case (priv_lvl_i)
        PRIV_LVL_M: mode = MODE_MACHINE;
        PRIV_LVL_S: mode = MODE_SUPERVISOR;
        default:    mode = MODE_USER;
      endcase
    end
  end

  always_comb begin
    for (int i = 0; i < NrPorts; i++) begin
      // trap cause top bit splits interrupts from exceptions
      if (!commit_ex_valid_i[i]) begin
        entry_d[i].kind = KIND_INSTR;
      end else if (commit_cause_i[i][IRQ_BIT]) begin
        entry_d[i].kind = KIND_INTERRUPT;
      end else begin
        entry_d[i].kind = KIND_EXCEPTION;
      end
      entry_d[i].mode  = mode;
      entry_d[i].port  = PORT_IDX_W'(i);
      entry_d[i].pc    = commit_pc_i[i];
      entry_d[i].cause = commit_cause_i[i];
      entry_d[i].tval  = commit_tval_i[i];
      entry_d[i].cycle = cycle_q;
    end
  end

  // ----------------------------------------
  // output registers
  // ----------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      push_q <= '0;
    end else begin
      push_q <= commit_ack_i;
    end
  end

  // payload only loads on an ack
  always_ff @(posedge clk_i) begin
    for (int i = 0; i < NrPorts; i++) begin
      if (commit_ack_i[i]) begin
        entry_q[i] <= entry_d[i];
      end
    end
  end

  assign push_o  = push_q;
  assign entry_o = entry_q;

endmodule

/* rtl/commit_trace_pkg.sv */
// commit trace definitions
// entry kinds, trace mode encoding and the record carried through the queues

package commit_trace_pkg;

  import core_cfg_pkg::*;

  // cycle stamp and drop counter width
  localparam int unsigned CYCLE_W = 32;

  // port index field sized for up to 8 commit ports
  localparam int unsigned PORT_IDX_W = 3;

  // what retired on a port
  typedef enum logic [1:0] {
    KIND_INSTR     = 2'b00,
    KIND_EXCEPTION = 2'b01,
    KIND_INTERRUPT = 2'b10
  } trace_kind_t;

  // debug mode overrides the privilege level
  typedef enum logic [1:0] {
    MODE_DEBUG      = 2'b00,
    MODE_MACHINE    = 2'b01,
    MODE_SUPERVISOR = 2'b10,
    MODE_USER       = 2'b11
  } trace_mode_t;

  // one trace record
  typedef struct packed {
    trace_kind_t           kind;
    trace_mode_t           mode;
    logic [PORT_IDX_W-1:0] port;
    logic [VLEN-1:0]       pc;
    logic [XLEN-1:0]       cause;
    logic [TVAL_W-1:0]     tval;
    logic [CYCLE_W-1:0]    cycle;
  } trace_entry_t;

endpackage

/* rtl/commit_trace_top.sv */
`timescale 1ns/1ps
// commit trace top level
// capture stage, one trace queue per commit port and the round-robin merge

module commit_trace_top import core_cfg_pkg::*, commit_trace_pkg::*; #(
  parameter int unsigned NrPorts    = 2,
  parameter int unsigned TraceDepth = 4
) (
  input  logic                           clk_i,
  input  logic                           rst_ni,
  // commit ports
  input  logic [NrPorts-1:0]             commit_ack_i,
  input  logic [NrPorts-1:0]             commit_ex_valid_i,
  input  logic [NrPorts-1:0][VLEN-1:0]   commit_pc_i,
  input  logic [NrPorts-1:0][XLEN-1:0]   commit_cause_i,
  input  logic [NrPorts-1:0][TVAL_W-1:0] commit_tval_i,
  input  priv_lvl_t                      priv_lvl_i,
  input  logic                           debug_mode_i,
  // merged trace
  output logic                           trace_valid_o,
  output trace_entry_t                   trace_entry_o,
  output logic [CYCLE_W-1:0]             drop_count_o
);

  logic [NrPorts-1:0]         push;
  trace_entry_t [NrPorts-1:0] entry;
  logic [NrPorts-1:0]         not_empty;
  trace_entry_t [NrPorts-1:0] head;
  logic [NrPorts-1:0]         pop;
  logic [NrPorts-1:0]         drop;

  // ----------------------------------------
  // capture
  // ----------------------------------------
  commit_capture #(
    .NrPorts ( NrPorts )
  ) u_capture (
    .clk_i             ( clk_i             ),
    .rst_ni            ( rst_ni            ),
    .commit_ack_i      ( commit_ack_i      ),
    .commit_ex_valid_i ( commit_ex_valid_i ),
    .commit_pc_i       ( commit_pc_i       ),
    .commit_cause_i    ( commit_cause_i    ),
    .commit_tval_i     ( commit_tval_i     ),
    .priv_lvl_i        ( priv_lvl_i        ),
    .debug_mode_i      ( debug_mode_i      ),
    .push_o            ( push              ),
    .entry_o           ( entry             )
  );

  // ----------------------------------------
  // per-port queues
  // ----------------------------------------
  for (genvar i = 0; i < NrPorts; i++) begin : gen_port
    trace_fifo #(
      .TraceDepth ( TraceDepth )
    ) u_fifo (
      .clk_i       ( clk_i        ),
      .rst_ni      ( rst_ni       ),
      .push_i      ( push[i]      ),
      .entry_i     ( entry[i]     ),
      .pop_i       ( pop[i]       ),
      .head_o      ( head[i]      ),
      .not_empty_o ( not_empty[i] ),
      .drop_o      ( drop[i]      )
    );
  end

  // merge onto the single trace output
  trace_rr_arbiter #(
    .NrPorts ( NrPorts )
  ) u_arb (
    .clk_i         ( clk_i         ),
    .rst_ni        ( rst_ni        ),
    .req_i         ( not_empty     ),
    .head_i        ( head          ),
    .drop_i        ( drop          ),
    .pop_o         ( pop           ),
    .trace_valid_o ( trace_valid_o ),
    .trace_entry_o ( trace_entry_o ),
    .drop_count_o  ( drop_count_o  )
  );

endmodule

/* rtl/core_cfg_pkg.sv */
// core configuration
// widths and privilege encodings of the core whose commits are traced

package core_cfg_pkg;

  // ----------------------------------------
  // datapath widths
  // ----------------------------------------
  // cause register width
  localparam int unsigned XLEN   = 64;
  // virtual program counter
  localparam int unsigned VLEN   = 39;
  // instruction word or trap value as recorded
  localparam int unsigned TVAL_W = 32;

  // interrupt flag sits in the top bit of the cause
  localparam int unsigned IRQ_BIT = XLEN - 1;

  // ----------------------------------------
  // privilege levels
  // ----------------------------------------
  // 2'b10 is reserved by the privileged spec
  typedef enum logic [1:0] {
    PRIV_LVL_U = 2'b00,
    PRIV_LVL_S = 2'b01,
    PRIV_LVL_M = 2'b11
  } priv_lvl_t;

endpackage

/* rtl/trace_fifo.sv */
`timescale 1ns/1ps
// trace queue
// first-word-fall-through circular buffer that drops and flags pushes when full

module trace_fifo import commit_trace_pkg::*; #(
  parameter int unsigned TraceDepth = 4
) (
  input  logic         clk_i,
  input  logic         rst_ni,
  input  logic         push_i,
  input  trace_entry_t entry_i,
  input  logic         pop_i,
  output trace_entry_t head_o,
  output logic         not_empty_o,
  output logic         drop_o
);

  localparam int unsigned PtrW = (TraceDepth > 1) ? $clog2(TraceDepth) : 1;
  localparam int unsigned CntW = $clog2(TraceDepth + 1);

  trace_entry_t    mem_q [TraceDepth];
  logic [PtrW-1:0] rd_ptr_q;
  logic [PtrW-1:0] wr_ptr_q;
  logic [CntW-1:0] count_q;
  logic            full;
  logic            empty;
  logic            do_push;
  logic            do_pop;

  // wrap at the last slot
  function automatic logic [PtrW-1:0] next_ptr(input logic [PtrW-1:0] ptr);
    return (ptr == PtrW'(TraceDepth - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign full  = (count_q == CntW'(TraceDepth));
  assign empty = (count_q == '0);

  // a pop frees the slot, so push and pop on a full queue both go through
  assign do_pop  = pop_i & ~empty;
  assign do_push = push_i & (~full | do_pop);
  assign drop_o  = push_i & full & ~do_pop;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rd_ptr_q <= '0;
      wr_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= next_ptr(wr_ptr_q);
      end
      if (do_pop) begin
        rd_ptr_q <= next_ptr(rd_ptr_q);
      end
      case ({do_push, do_pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  // storage
  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem_q[wr_ptr_q] <= entry_i;
    end
  end

  assign head_o      = mem_q[rd_ptr_q];
  assign not_empty_o = ~empty;

endmodule

/* rtl/trace_rr_arbiter.sv */
`timescale 1ns/1ps
// trace arbiter
// round-robin merge of the port queues onto one registered trace output

module trace_rr_arbiter import commit_trace_pkg::*; #(
  parameter int unsigned NrPorts = 2
) (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  logic [NrPorts-1:0]         req_i,
  input  trace_entry_t [NrPorts-1:0] head_i,
  input  logic [NrPorts-1:0]         drop_i,
  output logic [NrPorts-1:0]         pop_o,
  output logic                       trace_valid_o,
  output trace_entry_t               trace_entry_o,
  output logic [CYCLE_W-1:0]         drop_count_o
);

  localparam int unsigned IdxW = (NrPorts > 1) ? $clog2(NrPorts) : 1;
  localparam int unsigned SumW = $clog2(NrPorts + 1);

  logic [IdxW-1:0]    last_q;
  logic [IdxW-1:0]    gnt_idx;
  logic               gnt_valid;
  logic               trace_valid_q;
  trace_entry_t       trace_entry_q;
  logic [SumW-1:0]    drop_sum;
  logic [CYCLE_W:0]   drop_next;
  logic [CYCLE_W-1:0] drop_count_q;

  // ----------------------------------------
  // grant
  // ----------------------------------------
  // search starts one above the last grant and wraps
  always_comb begin
    int unsigned cand;
    gnt_valid = 1'b0;
    gnt_idx   = last_q;
    for (int unsigned k = 1; k <= NrPorts; k++) begin
      cand = (last_q + k) % NrPorts;
      if (!gnt_valid && req_i[cand]) begin
        gnt_valid = 1'b1;
        gnt_idx   = IdxW'(cand);
      end
    end
  end

  always_comb begin
    pop_o = '0;
    if (gnt_valid) begin
      pop_o[gnt_idx] = 1'b1;
    end
  end

  // ----------------------------------------
  // drop accounting
  // ----------------------------------------
  always_comb begin
    drop_sum = '0;
    for (int i = 0; i < NrPorts; i++) begin
      drop_sum = drop_sum + SumW'(drop_i[i]);
    end
    drop_next = {1'b0, drop_count_q} + (CYCLE_W + 1)'(drop_sum);
  end

  // port 0 wins the first pick after reset
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      last_q        <= IdxW'(NrPorts - 1);
      trace_valid_q <= 1'b0;
      drop_count_q  <= '0;
    end else begin
      trace_valid_q <= gnt_valid;
      if (gnt_valid) begin
        last_q <= gnt_idx;
      end
      // saturate on carry out
      if (drop_next[CYCLE_W]) begin
        drop_count_q <= '1;
      end else begin
        drop_count_q <= drop_next[CYCLE_W-1:0];
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (gnt_valid) begin
      trace_entry_q <= head_i[gnt_idx];
    end
  end

  assign trace_valid_o = trace_valid_q;
  assign trace_entry_o = trace_entry_q;
  assign drop_count_o  = drop_count_q;

endmodule

/* tb/tb_commit_trace.sv */
`timescale 1ns/1ps
// commit trace testbench
// directed and random commits checked against a cycle model of capture, queues and arbiter

module tb_commit_trace
  import core_cfg_pkg::*, commit_trace_pkg::*;
();

  localparam int NrPorts    = 2;
  localparam int TraceDepth = 4;
  // reset, five single commits, round robin, overflow, random run and six drains
  localparam int StimCycles = 8 + 5 * 16 + 5 + 12 + 400 + 6 * 40;
  localparam int Margin     = 200;

  logic                           clk_i = 1'b0;
  logic                           rst_ni;
  logic [NrPorts-1:0]             commit_ack_i;
  logic [NrPorts-1:0]             commit_ex_valid_i;
  logic [NrPorts-1:0][VLEN-1:0]   commit_pc_i;
  logic [NrPorts-1:0][XLEN-1:0]   commit_cause_i;
  logic [NrPorts-1:0][TVAL_W-1:0] commit_tval_i;
  priv_lvl_t                      priv_lvl_i;
  logic                           debug_mode_i;
  logic                           trace_valid_o;
  trace_entry_t                   trace_entry_o;
  logic [CYCLE_W-1:0]             drop_count_o;

  // model state
  trace_entry_t mq [NrPorts][$];
  trace_entry_t pend_entry [NrPorts];
  logic         pend_valid [NrPorts];
  trace_entry_t exp_entry;
  logic         exp_valid;
  int           exp_port;
  int           last_gnt;
  int           cyc;
  int           drop_exp;
  int           checked = 0;
  int           errors = 0;
  integer       seed = 32'h9383_0241;
  string        test_name = "reset";

  always #10 clk_i = ~clk_i;

  commit_trace_top #(
    .NrPorts    ( NrPorts    ),
    .TraceDepth ( TraceDepth )
  ) u_dut (
    .clk_i             ( clk_i             ),
    .rst_ni            ( rst_ni            ),
    .commit_ack_i      ( commit_ack_i      ),
    .commit_ex_valid_i ( commit_ex_valid_i ),
    .commit_pc_i       ( commit_pc_i       ),
    .commit_cause_i    ( commit_cause_i    ),
    .commit_tval_i     ( commit_tval_i     ),
    .priv_lvl_i        ( priv_lvl_i        ),
    .debug_mode_i      ( debug_mode_i      ),
    .trace_valid_o     ( trace_valid_o     ),
    .trace_entry_o     ( trace_entry_o     ),
    .drop_count_o      ( drop_count_o      )
  );

  // expected record for one acked commit
  function automatic trace_entry_t ref_entry(input int port, input logic ex,
      input logic [VLEN-1:0] pc, input logic [XLEN-1:0] cause, input logic [TVAL_W-1:0] tval,
      input priv_lvl_t priv, input logic dbg, input int stamp);
    trace_entry_t e;
    if (!ex) begin
      e.kind = KIND_INSTR;
    end else if (cause[XLEN-1]) begin
      e.kind = KIND_INTERRUPT;
    end else begin
      e.kind = KIND_EXCEPTION;
    end
    if (dbg) begin
      e.mode = MODE_DEBUG;
    end else if (priv == PRIV_LVL_M) begin
      e.mode = MODE_MACHINE;
    end else if (priv == PRIV_LVL_S) begin
      e.mode = MODE_SUPERVISOR;
    end else begin
      e.mode = MODE_USER;
    end
    e.port  = PORT_IDX_W'(port);
    e.pc    = pc;
    e.cause = cause;
    e.tval  = tval;
    e.cycle = CYCLE_W'(stamp);
    return e;
  endfunction

  task automatic check_field(input string field, input logic [XLEN-1:0] exp,
      input logic [XLEN-1:0] act);
    if (act !== exp) begin
      errors++;
      $display("mismatch %s %s: expected %h, actual %h", test_name, field, exp, act);
    end
  endtask

  // ----------------------------------------
  // cycle model and comparator
  // ----------------------------------------
  // samples pre-edge values, so outputs are checked against last cycle's prediction
  always @(posedge clk_i) begin : model
    int c;
    if (!rst_ni) begin
      cyc       = 0;
      last_gnt  = NrPorts - 1;
      exp_valid = 1'b0;
      drop_exp  = 0;
      for (int i = 0; i < NrPorts; i++) begin
        mq[i].delete();
        pend_valid[i] = 1'b0;
      end
    end else begin
      check_field("trace_valid", XLEN'(exp_valid), XLEN'(trace_valid_o));
      if (exp_valid && trace_valid_o) begin
        checked++;
        check_field("rr_port", XLEN'(exp_port), XLEN'(trace_entry_o.port));
        if (trace_entry_o !== exp_entry) begin
          errors++;
          $display("mismatch %s entry: expected %h, actual %h", test_name, exp_entry,
                   trace_entry_o);
        end
      end
      check_field("drop_count", XLEN'(drop_exp), XLEN'(drop_count_o));
      // round-robin pick from the queues as they stood before this edge
      exp_valid = 1'b0;
      for (int k = 1; k <= NrPorts; k++) begin
        c = (last_gnt + k) % NrPorts;
        if (!exp_valid && mq[c].size() != 0) begin
          exp_valid = 1'b1;
          exp_port  = c;
        end
      end
      if (exp_valid) begin
        exp_entry = mq[exp_port].pop_front();
        last_gnt  = exp_port;
      end
      // a full queue keeps its slot only if it was popped above
      for (int i = 0; i < NrPorts; i++) begin
        if (pend_valid[i] && mq[i].size() == TraceDepth) begin
          drop_exp++;
        end else if (pend_valid[i]) begin
          mq[i].push_back(pend_entry[i]);
        end
        pend_valid[i] = commit_ack_i[i];
        pend_entry[i] = ref_entry(i, commit_ex_valid_i[i], commit_pc_i[i], commit_cause_i[i],
                                  commit_tval_i[i], priv_lvl_i, debug_mode_i, cyc);
      end
      cyc++;
    end
  end

  // ----------------------------------------
  // stimulus tasks
  // ----------------------------------------
  task automatic drive_cycle(input logic [NrPorts-1:0] ack);
    @(posedge clk_i);
    commit_ack_i      <= ack;
    commit_ex_valid_i <= NrPorts'($random(seed));
    for (int i = 0; i < NrPorts; i++) begin
      commit_pc_i[i]    <= VLEN'({$random(seed), $random(seed)});
      commit_cause_i[i] <= {$random(seed), $random(seed)};
      commit_tval_i[i]  <= $random(seed);
    end
    case ($unsigned($random(seed)) % 3)
      0:       priv_lvl_i <= PRIV_LVL_U;
      1:       priv_lvl_i <= PRIV_LVL_S;
      default: priv_lvl_i <= PRIV_LVL_M;
    endcase
    debug_mode_i <= ($random(seed) & 7) == 0;
  endtask

  // one commit on an idle trace with latency and field checks
  task automatic single_commit(input int port, input logic ex, input logic [XLEN-1:0] cause,
      input priv_lvl_t priv, input logic dbg, input trace_kind_t kind_exp,
      input trace_mode_t mode_exp);
    logic [VLEN-1:0]   pc;
    logic [TVAL_W-1:0] tval;
    int                stamp;
    int                n;
    pc   = VLEN'({$random(seed), $random(seed)});
    tval = $random(seed);
    @(posedge clk_i);
    commit_ack_i            <= NrPorts'(1) << port;
    commit_ex_valid_i[port] <= ex;
    commit_pc_i[port]       <= pc;
    commit_cause_i[port]    <= cause;
    commit_tval_i[port]     <= tval;
    priv_lvl_i              <= priv;
    debug_mode_i            <= dbg;
    @(negedge clk_i);
    stamp = cyc;
    n = 0;
    do begin
      @(posedge clk_i);
      commit_ack_i <= '0;
      n++;
      @(negedge clk_i);
    end while (!trace_valid_o && n < 10);
    if (!trace_valid_o) begin
      errors++;
      $display("%s: no trace output within 10 cycles of the ack", test_name);
    end else begin
      check_field("latency", 3, n);
      check_field("kind", kind_exp, trace_entry_o.kind);
      check_field("mode", mode_exp, trace_entry_o.mode);
      check_field("port", port, trace_entry_o.port);
      check_field("pc", pc, trace_entry_o.pc);
      check_field("tval", tval, trace_entry_o.tval);
      check_field("stamp", stamp, trace_entry_o.cycle);
    end
  endtask

  task automatic wait_idle(input int max_cycles);
    int   n;
    logic busy;
    n    = 0;
    busy = 1'b1;
    @(posedge clk_i);
    commit_ack_i <= '0;
    while (busy && n < max_cycles) begin
      @(negedge clk_i);
      busy = exp_valid || trace_valid_o;
      for (int i = 0; i < NrPorts; i++) begin
        busy = busy || mq[i].size() != 0 || pend_valid[i];
      end
      n++;
    end
    if (busy) begin
      errors++;
      $display("%s: trace did not drain within %0d cycles", test_name, max_cycles);
    end
  endtask

  // ----------------------------------------
  // test sequence
  // ----------------------------------------
  initial begin : stimulus
    rst_ni            <= 1'b0;
    commit_ack_i      <= '0;
    commit_ex_valid_i <= '0;
    commit_pc_i       <= '0;
    commit_cause_i    <= '0;
    commit_tval_i     <= '0;
    priv_lvl_i        <= PRIV_LVL_M;
    debug_mode_i      <= 1'b0;
    repeat (8) @(posedge clk_i);
    rst_ni <= 1'b1;
    @(negedge clk_i);
    check_field("trace_valid", 0, trace_valid_o);
    check_field("drop_count", 0, drop_count_o);

    test_name = "single_instr";
    single_commit(0, 1'b0, 64'h0, PRIV_LVL_U, 1'b0, KIND_INSTR, MODE_USER);
    wait_idle(40);
    single_commit(1, 1'b0, 64'h0, PRIV_LVL_M, 1'b0, KIND_INSTR, MODE_MACHINE);
    wait_idle(40);
    test_name = "classify";
    single_commit(0, 1'b1, 64'h2, PRIV_LVL_M, 1'b0, KIND_EXCEPTION, MODE_MACHINE);
    single_commit(1, 1'b1, {1'b1, 63'd7}, PRIV_LVL_S, 1'b0, KIND_INTERRUPT, MODE_SUPERVISOR);
    single_commit(0, 1'b0, 64'h0, PRIV_LVL_U, 1'b1, KIND_INSTR, MODE_DEBUG);
    wait_idle(40);

    test_name = "round_robin";
    repeat (5) drive_cycle('1);
    wait_idle(40);
    test_name = "overflow";
    repeat (12) drive_cycle('1);
    wait_idle(40);
    if (drop_count_o == '0) begin
      errors++;
      $display("overflow: the trace queues dropped no entry");
    end

    test_name = "random";
    repeat (400) drive_cycle(NrPorts'($random(seed)));
    wait_idle(40);
    for (int i = 0; i < NrPorts; i++) begin
      check_field("queue_left", 0, mq[i].size());
    end
    check_field("drop_count", drop_exp, drop_count_o);

    $display("errors: %0d, entries checked: %0d, drops: %0d", errors, checked, drop_exp);
    if (errors == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

  initial begin : watchdog
    #((StimCycles + Margin) * 20);
    $display("timeout: the run did not finish in %0d cycles", StimCycles + Margin);
    $display("TESTS FAILED");
    $finish;
  end

endmodule
